//--- hdl/app_params.svh
`ifndef APP_PARAMS_SVH
`define APP_PARAMS_SVH

// link word as it arrives from the serial side
`define APP_WORD_W      32
`define APP_CHAN_W      3     // channel field in a header
`define APP_LEN_W       8     // payload length field in a header

// header reserved bits and payload data bits, both derived from the word
`define APP_RSVD_W      (`APP_WORD_W - 1 - `APP_CHAN_W - `APP_LEN_W)
`define APP_DATA_W      (`APP_WORD_W - 1)

// tagged beat = word + sop + eop + chan + err
`define APP_BEAT_W      (`APP_WORD_W + `APP_CHAN_W + 3)

`define APP_EB_DEPTH    4     // elastic buffer slots, also link side start credits
`define APP_OUT_CREDITS 3     // consumer credits after reset

`endif

//--- hdl/app_pkg.sv
`default_nettype none

`include "app_params.svh"

package app_pkg;

  ////////////////////////////////////////////////////////////
  // link word, two views of the same 32 bits
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                   kind;  // 1 = header
    logic [`APP_CHAN_W-1:0] chan;  // channel of the frame it opens
    logic [`APP_LEN_W-1:0]  len;   // payload words that follow
    logic [`APP_RSVD_W-1:0] rsvd;
  } app_hdr_t;

  typedef struct packed {
    logic                   kind;  // 0 = payload
    logic [`APP_DATA_W-1:0] data;
  } app_pay_t;

  typedef union packed {
    app_hdr_t hdr;
    app_pay_t pay;
  } app_word_u;

  ////////////////////////////////////////////////////////////
  // word plus the tags the parser attaches
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    app_word_u              word;
    logic                   sop;   // header word
    logic                   eop;   // last word of its frame
    logic [`APP_CHAN_W-1:0] chan;  // channel of the current frame
    logic                   err;   // framing error on this word
  } app_beat_t;

endpackage

`default_nettype wire

//--- hdl/app_frame_parser.sv
`default_nettype none

`include "app_params.svh"

module app_frame_parser (
  input  wire logic               clk,
  input  wire logic               rstz,
  input  wire logic               in_valid,  // one word per credit from the link
  input  wire app_pkg::app_word_u in_word,
  output logic                    wr,        // push into elastic buffer
  output app_pkg::app_beat_t      wr_beat
);

  logic [`APP_LEN_W-1:0]  remain;    // payload words still owed by the current frame
  logic [`APP_CHAN_W-1:0] cur_chan;  // channel of the frame in progress
  logic                   in_frame;

  logic [`APP_LEN_W-1:0]  remain_d;
  logic [`APP_CHAN_W-1:0] chan_d;
  app_pkg::app_beat_t     beat_d;

  assign in_frame = |remain;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    beat_d.word = in_word;
    beat_d.sop  = 1'b0;
    beat_d.eop  = 1'b0;
    beat_d.chan = cur_chan;
    beat_d.err  = 1'b0;
    remain_d    = remain;
    chan_d      = cur_chan;
    if (in_word.hdr.kind) begin
      // header, opens a new frame even if the old one was not done
      beat_d.sop  = 1'b1;
      beat_d.eop  = (in_word.hdr.len == '0);  // empty frame ends on its header
      beat_d.chan = in_word.hdr.chan;
      beat_d.err  = in_frame;                 // previous frame cut short
      remain_d    = in_word.hdr.len;
      chan_d      = in_word.hdr.chan;
    end else if (in_frame) begin
      remain_d   = remain - 1'b1;
      beat_d.eop = (remain_d == '0);  // last payload word
    end else begin
      // stray payload, keep last channel, no eop
      beat_d.err = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      remain   <= '0;
      cur_chan <= '0;
      wr       <= 1'b0;
    end else begin
      wr <= in_valid;        // one cycle through the parser
      if (in_valid) begin
        remain   <= remain_d;
        cur_chan <= chan_d;
      end
    end
  end

  // tagged word, only meaningful while wr is high
  always_ff @(posedge clk) begin
    if (in_valid) begin
      wr_beat <= beat_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/app_elastbuf.sv
`default_nettype none

`include "app_params.svh"

module app_elastbuf #(
  parameter int DEPTH = `APP_EB_DEPTH,  // slots, at least 2
  parameter int WIDTH = `APP_BEAT_W     // bits per slot
) (
  input  wire logic               clk,
  input  wire logic               rstz,
  input  wire logic               wr,       // write enable
  input  wire app_pkg::app_beat_t wr_beat,
  input  wire logic               rd,       // pop head
  output app_pkg::app_beat_t      rd_beat,  // always slot 0
  output logic                    emptyz,   // active low empty
  output logic                    fullz     // active low full
);

  // slot 0 is the head, data moves toward it on every read.
  // fill holds a run of ones from bit 0, one per occupied slot,
  // so the first free slot and the last filled slot are both
  // found by comparing the mask with itself shifted by one

  logic [DEPTH-1:0] fill;          // occupied slots
  logic [DEPTH-1:0] fill_rd;       // mask after a pop, bit i = slot i+1 filled
  logic [DEPTH-1:0] fill_wr;       // mask after a push, bit i = slot i-1 filled
  logic [DEPTH-1:0] free_slot;     // first empty slot
  logic [DEPTH-1:0] last_slot;     // highest filled slot
  logic [WIDTH-1:0] mem [DEPTH];   // shift slots
  logic [WIDTH-1:0] shift_in [DEPTH];  // what lands in slot i on a pop

  assign emptyz  = fill[0];
  assign fullz   = ~fill[DEPTH-1];
  assign rd_beat = mem[0];

  assign fill_rd   = {1'b0, fill[DEPTH-1:1]};
  assign fill_wr   = {fill[DEPTH-2:0], 1'b1};
  assign free_slot = ~fill & fill_wr;
  assign last_slot = fill & ~fill_rd;

  ////////////////////////////////////////////////////////////
  // fill mask
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      fill <= '0;
    end else begin
      case ({rd, wr})
        2'b10:   fill <= fill_rd;  // pop, shift right
        2'b01:   fill <= fill_wr;  // push, shift left with a one
        default: fill <= fill;     // idle, or pop and push cancel
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // next value per slot on a pop
  ////////////////////////////////////////////////////////////
  for (genvar g = 0; g < DEPTH; g++) begin : g_shift
    if (g == DEPTH - 1) begin : g_top
      assign shift_in[g] = '0;  // nothing above the top slot
    end else begin : g_mid
      // an empty neighbour pulls in zero, so vacated slots clear
      assign shift_in[g] = fill_rd[g] ? mem[g+1] : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // slots
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        case ({rd, wr})
          2'b10: begin
            mem[i] <= shift_in[i];
          end
          2'b01: begin
            if (free_slot[i]) begin
              mem[i] <= wr_beat;      // lands behind the last entry
            end
          end
          2'b11: begin
            if (last_slot[i]) begin
              mem[i] <= wr_beat;      // takes the place the shift just freed
            end else begin
              mem[i] <= shift_in[i];
            end
          end
          default: begin
            mem[i] <= mem[i];
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/app_credit_tx.sv
`default_nettype none

`include "app_params.svh"

module app_credit_tx (
  input  wire logic               clk,
  input  wire logic               rstz,
  input  wire app_pkg::app_beat_t head_beat,   // buffer slot 0
  input  wire logic               emptyz,      // buffer holds a beat
  input  wire logic               out_credit,  // consumer freed one beat
  output logic                    rd,          // pop buffer head
  output logic                    in_credit,   // slot freed, back to the link
  output logic                    out_valid,
  output app_pkg::app_beat_t      out_beat
);

  localparam int CNT_W = $clog2(`APP_OUT_CREDITS + 1);

  logic [CNT_W-1:0] credits;  // beats the consumer can still take

  // pop whenever a beat waits and the consumer has room
  assign rd = (credits != '0) & emptyz;

  ////////////////////////////////////////////////////////////
  // consumer credits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      credits <= CNT_W'(`APP_OUT_CREDITS);
    end else begin
      case ({rd, out_credit})
        2'b10:   credits <= credits - 1'b1;  // spent on a beat
        2'b01:   credits <= credits + 1'b1;  // returned
        default: credits <= credits;         // both or neither
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= rd;
      in_credit <= rd;  // popped slot is free again on the link side
    end
  end

  // payload follows the pop, held between beats
  always_ff @(posedge clk) begin
    if (rd) begin
      out_beat <= head_beat;
    end
  end

endmodule

`default_nettype wire

//--- hdl/app_rx_top.sv
`default_nettype none

`include "app_params.svh"

module app_rx_top (
  input  wire logic               clk,
  input  wire logic               rstz,
  // link side
  input  wire logic               in_valid,
  input  wire app_pkg::app_word_u in_word,
  output logic                    in_credit,
  // consumer side
  output logic                    out_valid,
  output app_pkg::app_beat_t      out_beat,
  input  wire logic               out_credit
);

  logic               wr;         // parser to buffer
  app_pkg::app_beat_t wr_beat;
  logic               rd;         // transmitter pops buffer
  app_pkg::app_beat_t head_beat;
  logic               emptyz;

  ////////////////////////////////////////////////////////////
  // parse, buffer, transmit
  ////////////////////////////////////////////////////////////
  app_frame_parser app_frame_parser_i (
    .clk      (clk),
    .rstz     (rstz),
    .in_valid (in_valid),
    .in_word  (in_word),
    .wr       (wr),
    .wr_beat  (wr_beat)
  );

  app_elastbuf #(
    .DEPTH (`APP_EB_DEPTH),
    .WIDTH (`APP_BEAT_W)
  ) app_elastbuf_i (
    .clk     (clk),
    .rstz    (rstz),
    .wr      (wr),
    .wr_beat (wr_beat),
    .rd      (rd),
    .rd_beat (head_beat),
    .emptyz  (emptyz),
    .fullz   ()            // link credits keep writes off a full buffer
  );

  app_credit_tx app_credit_tx_i (
    .clk        (clk),
    .rstz       (rstz),
    .head_beat  (head_beat),
    .emptyz     (emptyz),
    .out_credit (out_credit),
    .rd         (rd),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
  );

endmodule

`default_nettype wire

//--- verification/app_rx_tb.sv
`default_nettype none

`include "app_params.svh"

module app_rx_tb;

  typedef struct packed {
    logic [8*16-1:0] name;   // test name from the marker line
    logic            rnd;    // random out_credit delays
    int              first;  // index of its first word in stim
  } test_t;

  logic               clk;
  logic               rstz;
  logic               in_valid;
  app_pkg::app_word_u in_word;
  logic               in_credit;
  logic               out_valid;
  app_pkg::app_beat_t out_beat;
  logic               out_credit = 1'b0;

  test_t              tests[$];
  app_pkg::app_beat_t stim[$];         // words with their expected tags
  app_pkg::app_beat_t exp_q[$];        // sent but not yet seen at the output
  int unsigned        due_q[$];        // cycles at which out_credit goes back
  logic               stim_loaded = 1'b0;
  logic               rnd_mode = 1'b0;
  int unsigned        rng = 76605;
  int unsigned        cyc = 0;
  int                 sent_cnt = 0;    // words handed to the link
  int                 ret_cnt = 0;     // in_credit pulses seen
  int                 beat_cnt = 0;    // out beats seen
  int                 err_cnt = 0;

  app_rx_top app_rx_top_i (
    .clk        (clk),
    .rstz       (rstz),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  always begin
    clk = 1'b0;
    #20;
    clk = 1'b1;
    #20;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic int unsigned next_rand(input int unsigned x);
    int unsigned s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic compare_beat(input app_pkg::app_beat_t got, input app_pkg::app_beat_t want);
    if (got !== want) begin
      $display("ERROR: out_beat got %h expected %h", got, want);
      err_cnt++;
    end
  endtask

  task automatic compare_count(input string what, input int got, input int want);
    if (got !== want) begin
      $display("ERROR: %s got %h expected %h", what, got, want);
      err_cnt++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // marker lines open a test and w lines add a word to the last one
  task automatic load_stim(output bit ok);
    int                 fd;
    int                 n;
    bit                 done;
    logic [8*16-1:0]    tok;
    logic [8*16-1:0]    nm;
    logic [8*128-1:0]   rest;
    logic [31:0]        w;
    int                 sop;
    int                 eop;
    int                 chan;
    int                 err;
    test_t              t;
    app_pkg::app_beat_t b;
    ok   = 1'b0;
    done = 1'b0;
    fd   = $fopen("verification/app_rx_stim.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (ok && !done) begin
        tok = '0;
        n   = $fscanf(fd, "%s", tok);
        if (n != 1) begin
          done = 1'b1;                          // end of file
        end else if (tok == "#") begin
          n = $fgets(rest, fd);                 // column notes
        end else if (tok == "test") begin
          nm = '0;
          n  = $fscanf(fd, "%s %s", nm, tok);
          ok = (tok == "steady") || (tok == "random");
          t.name  = nm;
          t.rnd   = (tok == "random");
          t.first = stim.size();
          tests.push_back(t);
        end else if (tok == "w" && tests.size() > 0) begin
          n = $fscanf(fd, "%h %d %d %d %d", w, sop, eop, chan, err);
          ok     = (n == 5);
          b.word = w;
          b.sop  = sop[0];
          b.eop  = eop[0];
          b.chan = chan[`APP_CHAN_W-1:0];
          b.err  = err[0];
          stim.push_back(b);
        end else begin
          ok = 1'b0;                            // stray token
        end
      end
      $fclose(fd);
      ok = ok && (stim.size() > 0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitors and consumer
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin : link_credit_monitor
    if (in_credit) begin
      ret_cnt++;
      if (ret_cnt > sent_cnt) begin
        $display("in_credit returned for a word that was never sent");
        err_cnt++;
      end
    end
  end

  always @(posedge clk) begin : out_monitor
    if (out_valid) begin
      beat_cnt++;
      if (exp_q.size() == 0) begin
        $display("extra beat on the output with nothing sent for it");
        err_cnt++;
      end else begin
        compare_beat(out_beat, exp_q.pop_front());
      end
    end
  end

  // one out_credit per beat with pulses kept in order and one per cycle
  always @(posedge clk) begin : credit_responder
    int unsigned delay;
    cyc++;
    if (out_valid) begin
      delay = 0;
      if (rnd_mode) begin
        rng   = next_rand(rng);
        delay = rng % 8;
      end
      if (due_q.size() > 0 && due_q[$] >= cyc + delay) begin
        due_q.push_back(due_q[$] + 1);
      end else begin
        due_q.push_back(cyc + delay);
      end
    end
    #2;
    if (due_q.size() > 0 && due_q[0] <= cyc) begin
      out_credit = 1'b1;
      void'(due_q.pop_front());
    end else begin
      out_credit = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  task automatic run_all();
    int pass_n;
    int fail_n;
    int last;
    int errs0;
    int sent0;
    int ret0;
    int beats0;
    int drain_n;
    pass_n = 0;
    fail_n = 0;
    for (int i = 0; i < tests.size(); i++) begin
      last     = (i + 1 < tests.size()) ? tests[i+1].first : stim.size();
      errs0    = err_cnt;
      sent0    = sent_cnt;
      ret0     = ret_cnt;
      beats0   = beat_cnt;
      rnd_mode = tests[i].rnd;
      for (int k = tests[i].first; k < last; k++) begin
        while (sent_cnt - ret_cnt >= `APP_EB_DEPTH) begin  // link side out of credit
          in_valid = 1'b0;
          @(posedge clk);
          #2;
        end
        in_valid = 1'b1;
        in_word  = stim[k].word;
        exp_q.push_back(stim[k]);
        sent_cnt++;
        @(posedge clk);
        #2;
      end
      in_valid = 1'b0;
      drain_n  = 0;
      while ((exp_q.size() > 0 || ret_cnt != sent_cnt || due_q.size() > 0) && drain_n < 200) begin
        @(posedge clk);
        #2;
        drain_n++;
      end
      repeat (8) @(posedge clk);  // room for a stray extra beat
      #2;
      if (exp_q.size() > 0) begin
        $display("test %0s: %0d beats never came out", tests[i].name, exp_q.size());
        err_cnt++;
        exp_q.delete();
      end
      compare_count("in_credit", ret_cnt - ret0, sent_cnt - sent0);
      compare_count("out_valid", beat_cnt - beats0, sent_cnt - sent0);
      compare_count("link_credits", `APP_EB_DEPTH - (sent_cnt - ret_cnt), `APP_EB_DEPTH);
      if (err_cnt == errs0) begin
        pass_n++;
        $display("test %0s: pass, %0d words", tests[i].name, sent_cnt - sent0);
      end else begin
        fail_n++;
        $display("test %0s: fail, %0d errors", tests[i].name, err_cnt - errs0);
      end
    end
    $display("tests passed %0d failed %0d", pass_n, fail_n);
    if (fail_n == 0 && err_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("one or more checks failed");
    end
  endtask

  initial begin : main
    bit ok;
    rstz     = 1'b0;
    in_valid = 1'b0;
    in_word  = '0;
    load_stim(ok);
    stim_loaded = ok;
    if (!ok) begin
      abort_run("stimulus file missing or malformed");
    end else begin
      repeat (3) @(posedge clk);  // reset held 3 cycles
      #2;
      rstz = 1'b1;
      @(posedge clk);
      #2;
      run_all();
    end
  end

  // bound scales with the number of words
  initial begin : watchdog
    wait (stim_loaded);
    repeat (200 * stim.size() + 1000) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

//--- app_rx.f
+incdir+hdl
hdl/app_pkg.sv
hdl/app_frame_parser.sv
hdl/app_elastbuf.sv
hdl/app_credit_tx.sv
hdl/app_rx_top.sv
verification/app_rx_tb.sv

//--- Makefile
# Verilator run of the receive path testbench
TOP = app_rx_tb

sim:
	verilator --binary --timing -Wno-fatal -f app_rx.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- verification/app_rx_stim.txt
# test <name> <steady|random>   out_credit returns at once or after 0..7 cycles
# w <word hex> <sop> <eop> <chan> <err>   word and the tags expected on it
test frames steady
w A0300000 1 0 2 0
w 12345678 0 0 2 0
w 0badf00d 0 0 2 0
w 7fffffff 0 1 2 0
w D0000000 1 1 5 0
w 80112345 1 0 0 0
w 00c0ffee 0 1 0 0
test errors steady
w 11111111 0 0 0 1
w B0200000 1 0 3 0
w 22222222 0 0 3 0
w C0100000 1 0 4 1
w 33333333 0 1 4 0
w 44444444 0 0 4 1
w 90000000 1 1 1 0
test backpressure random
w B0700000 1 0 3 0
w 3c000001 0 0 3 0
w 3c000002 0 0 3 0
w 3c000003 0 0 3 0
w 3c000004 0 0 3 0
w 3c000005 0 0 3 0
w 3c000006 0 0 3 0
w 3c000007 0 1 3 0
w D0000000 1 1 5 0
test stream steady
w A0400000 1 0 2 0
w 7e000001 0 0 2 0
w 7e000002 0 0 2 0
w 7e000003 0 0 2 0
w 7e000004 0 1 2 0
w 80000000 1 1 0 0
